//--- gcode_parser.f
+incdir+src
src/gcode_pkg.sv
src/subparser_if.sv
src/number_accumulator.sv
src/subparser_input_chooser.sv
src/gcode_parser_fsm.sv
src/coord_subparser.sv
src/line_skipper.sv
src/gcode_parser.sv
tests/tb_clock_gen.sv
tests/gcode_checker.sv
tests/gcode_parser_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the gcode_parser testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module gcode_parser_tb -f gcode_parser.f -o gcode_parser_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/gcode_parser_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- src/coord_subparser.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module coord_subparser import gcode_pkg::*; #(
	parameter bit ARC_WORDS = 1'b0      // Accept I and J
) (
	input  logic                              clk,
	input  logic                              rst_n,
	subparser_if.sub                          sub,
	input  logic [`GC_CHAR_BITS-1:0]          rd_char,
	output logic signed [`GC_COORD_BITS-1:0]  coord_x,
	output logic signed [`GC_COORD_BITS-1:0]  coord_y,
	output logic signed [`GC_COORD_BITS-1:0]  coord_i,
	output logic signed [`GC_COORD_BITS-1:0]  coord_j
);

	sub_state_e state;

	logic       rd_pending;
	logic       fail;          // Line rejected, still consumed to the newline
	logic       got_minus;
	logic [1:0] axis;          // X, Y, I, J
	logic [3:0] seen;
	logic       is_letter;
	logic [1:0] letter_axis;
	logic       axis_ok;
	logic       is_digit;
	logic       is_end;
	logic       minus_en;
	logic       digit_en;

	logic signed [`GC_COORD_BITS-1:0]  acc_value;
	logic [`GC_DIGIT_CNT_BITS-1:0]     acc_count;
	logic                              acc_ovf;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign sub.rdy        = (state == WAIT_TRIG);
	assign sub.done       = (state == FINISH);
	assign sub.success    = (state == FINISH) && !fail;
	assign sub.newline    = (state == FINISH);
	assign sub.rd_trigger = sub.rd_rdy && !sub.is_empty && !rd_pending &&
		((state == READ_AXIS) || (state == READ_VALUE));

	always_comb begin
		is_letter   = 1'b1;
		letter_axis = 2'd0;
		case (rd_char)
			"X":     letter_axis = 2'd0;
			"Y":     letter_axis = 2'd1;
			"I":     letter_axis = 2'd2;
			"J":     letter_axis = 2'd3;
			default: is_letter = 1'b0;
		endcase
	end

	assign axis_ok  = is_letter && (ARC_WORDS || !letter_axis[1]) && !seen[letter_axis];
	assign is_digit = (rd_char >= "0") && (rd_char <= "9");
	assign is_end   = (rd_char == " ") || (rd_char == "\n");
	assign minus_en = (state == READ_VALUE) && sub.rd_done && (rd_char == "-") &&
		(acc_count == '0) && !got_minus;
	assign digit_en = (state == READ_VALUE) && sub.rd_done && is_digit;

	number_accumulator i_value (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       ((state == READ_AXIS) && sub.rd_done && axis_ok),
		.digit_en    (digit_en),
		.minus_en    (minus_en),
		.digit       (rd_char[3:0]),
		.value       (acc_value),
		.digit_count (acc_count),
		.overflow    (acc_ovf)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= WAIT_TRIG;
			rd_pending <= 1'b0;
			fail       <= 1'b0;
			got_minus  <= 1'b0;
			axis       <= 2'd0;
			seen       <= '0;
			coord_x    <= '0;
			coord_y    <= '0;
			coord_i    <= '0;
			coord_j    <= '0;
		end else begin
			if (sub.rd_trigger)
				rd_pending <= 1'b1;
			else if (sub.rd_done)
				rd_pending <= 1'b0;

			case (state)
				WAIT_TRIG: if (sub.trigger) begin
					coord_x <= '0;     // Missing axes read as zero
					coord_y <= '0;
					coord_i <= '0;
					coord_j <= '0;
					seen    <= '0;
					fail    <= 1'b0;
					state   <= READ_AXIS;
				end
				READ_AXIS: if (sub.rd_done) begin
					if (rd_char == "\n") begin
						state <= FINISH;
					end else if (axis_ok) begin
						axis              <= letter_axis;
						seen[letter_axis] <= 1'b1;
						got_minus         <= 1'b0;
						state             <= READ_VALUE;
					end else if (rd_char != " ") begin
						fail <= 1'b1;      // Bad or repeated letter
					end
				end
				READ_VALUE: if (sub.rd_done) begin
					if (is_end) begin
						if (acc_count == '0 || acc_ovf)
							fail <= 1'b1;
						else begin
							case (axis)
								2'd0: coord_x <= acc_value;
								2'd1: coord_y <= acc_value;
								2'd2: coord_i <= acc_value;
								default: coord_j <= acc_value;
							endcase
						end
						state <= (rd_char == "\n") ? FINISH : READ_AXIS;
					end else if (minus_en) begin
						got_minus <= 1'b1;
					end else if (!is_digit) begin
						fail <= 1'b1;
					end
				end
				FINISH:  state <= WAIT_TRIG;
				default: state <= WAIT_TRIG;
			endcase
		end
	end

	// Trigger comes from the FSM through the chooser
	a_done_trigger: assert property (@(posedge clk) disable iff (!rst_n)
		!(sub.done && sub.trigger))
		else $error("done and trigger high together");

endmodule : coord_subparser

//--- src/gcode_defines.svh
`ifndef GCODE_DEFINES_SVH
`define GCODE_DEFINES_SVH

// One character from the reader
`define GC_CHAR_BITS 8

// Signed coordinate as emitted on op_x .. op_j
`define GC_COORD_BITS 16

// Digits allowed in one number word, one more is a format error
`define GC_MAX_DIGITS 4

// Width of the command code
`define GC_OP_CMD_BITS 3

// Digit counter must reach GC_MAX_DIGITS + 1
`define GC_DIGIT_CNT_BITS ($clog2(`GC_MAX_DIGITS + 2))

`endif

//--- src/gcode_parser.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module gcode_parser import gcode_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	output logic                              rd_trigger,
	input  logic                              rd_done,
	input  logic [`GC_CHAR_BITS-1:0]          rd_char,
	input  logic                              is_empty,
	output logic                              op_valid,
	output logic                              op_error,
	output op_cmd_e                           op_cmd,
	output logic                              op_abs,
	output logic signed [`GC_COORD_BITS-1:0]  op_x,
	output logic signed [`GC_COORD_BITS-1:0]  op_y,
	output logic signed [`GC_COORD_BITS-1:0]  op_i,
	output logic signed [`GC_COORD_BITS-1:0]  op_j
);

	subparser_if fsm_if ();
	subparser_if lin_if ();
	subparser_if arc_if ();
	subparser_if skip_if ();

	logic signed [`GC_COORD_BITS-1:0] lin_x, lin_y, lin_i, lin_j;
	logic signed [`GC_COORD_BITS-1:0] arc_x, arc_y, arc_i, arc_j;
	logic                             use_arc;

	gcode_parser_fsm i_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_trigger (rd_trigger),
		.rd_done    (rd_done),
		.rd_char    (rd_char),
		.is_empty   (is_empty),
		.sub        (fsm_if.parser),
		.cmd        (op_cmd),
		.op_valid   (op_valid),
		.op_error   (op_error),
		.op_abs     (op_abs)
	);

	subparser_input_chooser i_chooser (
		.cmd      (op_cmd),
		.sub_in   (fsm_if.sub),
		.lin_out  (lin_if.parser),
		.arc_out  (arc_if.parser),
		.skip_out (skip_if.parser)
	);

	coord_subparser #(.ARC_WORDS(1'b0)) i_lin (
		.clk(clk), .rst_n(rst_n), .sub(lin_if.sub), .rd_char(rd_char),
		.coord_x(lin_x), .coord_y(lin_y), .coord_i(lin_i), .coord_j(lin_j)
	);

	coord_subparser #(.ARC_WORDS(1'b1)) i_arc (
		.clk(clk), .rst_n(rst_n), .sub(arc_if.sub), .rd_char(rd_char),
		.coord_x(arc_x), .coord_y(arc_y), .coord_i(arc_i), .coord_j(arc_j)
	);

	line_skipper i_skip (
		.clk     (clk),
		.rst_n   (rst_n),
		.sub     (skip_if.sub),
		.rd_char (rd_char)
	);

	// Linear instance never writes I and J, so they read 0
	assign use_arc = (op_cmd == OP_CMD_G02) || (op_cmd == OP_CMD_G03);
	assign op_x    = use_arc ? arc_x : lin_x;
	assign op_y    = use_arc ? arc_y : lin_y;
	assign op_i    = use_arc ? arc_i : lin_i;
	assign op_j    = use_arc ? arc_j : lin_j;

endmodule : gcode_parser

//--- src/gcode_parser_fsm.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module gcode_parser_fsm import gcode_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	output logic                       rd_trigger,
	input  logic                       rd_done,
	input  logic [`GC_CHAR_BITS-1:0]   rd_char,
	input  logic                       is_empty,
	subparser_if.parser                sub,
	output op_cmd_e                    cmd,
	output logic                       op_valid,
	output logic                       op_error,
	output logic                       op_abs
);

	parser_state_e state;
	parser_state_e state_nxt;

	logic rd_pending;   // Any request outstanding on the reader
	logic own_state;    // FSM holds the reader itself
	logic lent;
	logic own_trig;
	logic char_done;
	logic is_digit;
	logic digit_en;

	logic signed [`GC_COORD_BITS-1:0]  acc_value;
	logic [`GC_DIGIT_CNT_BITS-1:0]     acc_count;
	logic                              acc_ovf;

	function automatic op_cmd_e decode_g(input logic signed [`GC_COORD_BITS-1:0] num);
		case (num)
			0:       return OP_CMD_G00;
			1:       return OP_CMD_G01;
			2:       return OP_CMD_G02;
			3:       return OP_CMD_G03;
			90:      return OP_CMD_G90;
			91:      return OP_CMD_G91;
			default: return OP_CMD_NONE;
		endcase
	endfunction

	assign own_state = (state == READ_LETTER) || (state == READ_NUMBER);
	assign lent      = (state == DISPATCH) || (state == WAIT_SUB);
	assign own_trig  = own_state && !rd_pending && !is_empty;
	assign char_done = own_state && rd_done;
	assign is_digit  = (rd_char >= "0") && (rd_char <= "9");
	assign digit_en  = char_done && (state == READ_NUMBER) && is_digit;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reader sharing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rd_trigger   = own_trig || (lent && sub.rd_trigger);
	assign sub.rd_done  = lent && rd_done;
	assign sub.rd_rdy   = lent;
	assign sub.is_empty = is_empty;
	assign sub.trigger  = (state == DISPATCH) && sub.rdy;

	number_accumulator i_g_number (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (state == IDLE),
		.digit_en    (digit_en),
		.minus_en    (1'b0),       // G words carry no sign
		.digit       (rd_char[3:0]),
		.value       (acc_value),
		.digit_count (acc_count),
		.overflow    (acc_ovf)
	);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:        state_nxt = READ_LETTER;
			READ_LETTER: if (char_done) begin
				if (rd_char == "\n")
					state_nxt = EMIT;        // Empty line
				else if (rd_char == "G")
					state_nxt = READ_NUMBER;
				else
					state_nxt = DISPATCH;    // Skipper eats the rest
			end
			READ_NUMBER: if (char_done) begin
				if (rd_char == "\n")
					state_nxt = EMIT;        // G word needs a trailing space
				else if (!is_digit)
					state_nxt = DISPATCH;
			end
			DISPATCH:    if (sub.rdy) state_nxt = WAIT_SUB;
			WAIT_SUB:    if (sub.done) state_nxt = EMIT;
			EMIT:        state_nxt = IDLE;
			default:     state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			rd_pending <= 1'b0;
			cmd        <= OP_CMD_NONE;
			op_valid   <= 1'b0;
			op_error   <= 1'b0;
			op_abs     <= 1'b1;   // Absolute mode out of reset
		end else begin
			state    <= state_nxt;
			op_valid <= 1'b0;
			op_error <= 1'b0;

			if (rd_trigger)
				rd_pending <= 1'b1;
			else if (rd_done)
				rd_pending <= 1'b0;

			if (state == IDLE)
				cmd <= OP_CMD_NONE;
			else if (char_done && (state == READ_NUMBER) && (rd_char == " "))
				cmd <= (acc_count == '0 || acc_ovf) ? OP_CMD_NONE : decode_g(acc_value);

			if ((state == WAIT_SUB) && sub.done) begin
				if (sub.success && sub.newline && (cmd != OP_CMD_NONE))
					op_valid <= 1'b1;
				else
					op_error <= 1'b1;
				if (sub.success && (cmd == OP_CMD_G90))
					op_abs <= 1'b1;
				if (sub.success && (cmd == OP_CMD_G91))
					op_abs <= 1'b0;
			end else if (char_done && (rd_char == "\n")) begin
				op_error <= 1'b1;    // Line ended inside the G word
			end
		end
	end

	// Covers requests from the subparsers too
	a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
		rd_trigger |-> !rd_pending)
		else $error("rd_trigger issued while a read is outstanding");

endmodule : gcode_parser_fsm

//--- src/gcode_pkg.sv
`include "gcode_defines.svh"

package gcode_pkg;

	// Decoded G word
	typedef enum logic [`GC_OP_CMD_BITS-1:0] {
		OP_CMD_G00,
		OP_CMD_G01,
		OP_CMD_G02,
		OP_CMD_G03,
		OP_CMD_G90,
		OP_CMD_G91,
		OP_CMD_NONE   // Unknown or malformed G word
	} op_cmd_e;

	// Line-level parser
	typedef enum logic [2:0] {
		IDLE,
		READ_LETTER,
		READ_NUMBER,
		DISPATCH,
		WAIT_SUB,
		EMIT
	} parser_state_e;

	// Axis word reader
	typedef enum logic [1:0] {
		WAIT_TRIG,
		READ_AXIS,
		READ_VALUE,
		FINISH
	} sub_state_e;

endpackage : gcode_pkg

//--- src/line_skipper.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module line_skipper (
	input  logic                       clk,
	input  logic                       rst_n,
	subparser_if.sub                   sub,
	input  logic [`GC_CHAR_BITS-1:0]   rd_char
);

	logic busy;         // Consuming the line
	logic finish;       // Newline seen, done this cycle
	logic rd_pending;

	assign sub.rdy        = !busy && !finish;
	assign sub.done       = finish;
	assign sub.success    = finish;   // Error decision stays with the FSM
	assign sub.newline    = finish;
	assign sub.rd_trigger = busy && sub.rd_rdy && !sub.is_empty && !rd_pending;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			finish     <= 1'b0;
			rd_pending <= 1'b0;
		end else begin
			finish <= 1'b0;
			if (sub.rd_trigger)
				rd_pending <= 1'b1;
			else if (sub.rd_done)
				rd_pending <= 1'b0;

			if (sub.trigger)
				busy <= 1'b1;
			else if (busy && sub.rd_done && (rd_char == "\n")) begin
				busy   <= 1'b0;
				finish <= 1'b1;
			end
		end
	end

endmodule : line_skipper

//--- src/number_accumulator.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module number_accumulator (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               clear,
	input  logic                               digit_en,
	input  logic                               minus_en,
	input  logic [3:0]                         digit,
	output logic signed [`GC_COORD_BITS-1:0]   value,
	output logic [`GC_DIGIT_CNT_BITS-1:0]      digit_count,
	output logic                               overflow
);

	localparam logic [`GC_DIGIT_CNT_BITS-1:0] MAX_CNT = `GC_MAX_DIGITS;

	logic [`GC_COORD_BITS-1:0] magnitude;
	logic                      negative;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			magnitude   <= '0;
			negative    <= 1'b0;
			digit_count <= '0;
		end else if (clear) begin
			magnitude   <= '0;
			negative    <= 1'b0;
			digit_count <= '0;
		end else begin
			if (minus_en)
				negative <= 1'b1;
			if (digit_en) begin
				if (digit_count <= MAX_CNT)
					digit_count <= digit_count + 1'b1;   // Saturates one past the limit
				if (digit_count < MAX_CNT)
					magnitude <= magnitude * `GC_COORD_BITS'(10) + `GC_COORD_BITS'(digit);
			end
		end
	end

	assign overflow = digit_count > MAX_CNT;
	assign value    = negative ? -$signed(magnitude) : $signed(magnitude);

	// Callers decode one character per cycle
	a_sign_or_digit: assert property (@(posedge clk) disable iff (!rst_n)
		!(digit_en && minus_en))
		else $error("minus_en and digit_en high together");

endmodule : number_accumulator

//--- src/subparser_if.sv
`timescale 1ns/100ps

interface subparser_if;

	logic trigger;      // Start of the subparser, one cycle
	logic done;         // End of line reached, one cycle
	logic rdy;          // Subparser idle and able to take trigger
	logic rd_trigger;   // Character request from the subparser
	logic rd_done;      // Character returned by the reader
	logic rd_rdy;       // Reader lent to the subparser
	logic is_empty;     // Reader has nothing to give
	logic success;      // Valid with done
	logic newline;      // Valid with done, line consumed through the newline

	// Line-level side
	modport parser (
		output trigger, rd_done, rd_rdy, is_empty,
		input  done, rdy, rd_trigger, success, newline
	);

	// Subparser side
	modport sub (
		input  trigger, rd_done, rd_rdy, is_empty,
		output done, rdy, rd_trigger, success, newline
	);

endinterface : subparser_if

//--- src/subparser_input_chooser.sv
`timescale 1ns/100ps

module subparser_input_chooser import gcode_pkg::*; (
	input  op_cmd_e       cmd,
	subparser_if.sub      sub_in,
	subparser_if.parser   lin_out,
	subparser_if.parser   arc_out,
	subparser_if.parser   skip_out
);

	logic lin_sel;
	logic arc_sel;
	logic skip_sel;

	always_comb begin
		lin_sel  = 1'b0;
		arc_sel  = 1'b0;
		skip_sel = 1'b0;
		case (cmd)
			OP_CMD_G00, OP_CMD_G01: lin_sel = 1'b1;
			OP_CMD_G02, OP_CMD_G03: arc_sel = 1'b1;
			default:                skip_sel = 1'b1;   // G90, G91 and bad lines
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Forward path, idle subparsers see all zeros
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lin_out.trigger   = lin_sel & sub_in.trigger;
	assign lin_out.rd_done   = lin_sel & sub_in.rd_done;
	assign lin_out.rd_rdy    = lin_sel & sub_in.rd_rdy;
	assign lin_out.is_empty  = lin_sel & sub_in.is_empty;

	assign arc_out.trigger   = arc_sel & sub_in.trigger;
	assign arc_out.rd_done   = arc_sel & sub_in.rd_done;
	assign arc_out.rd_rdy    = arc_sel & sub_in.rd_rdy;
	assign arc_out.is_empty  = arc_sel & sub_in.is_empty;

	assign skip_out.trigger  = skip_sel & sub_in.trigger;
	assign skip_out.rd_done  = skip_sel & sub_in.rd_done;
	assign skip_out.rd_rdy   = skip_sel & sub_in.rd_rdy;
	assign skip_out.is_empty = skip_sel & sub_in.is_empty;

	// Return path from the selected subparser
	always_comb begin
		if (lin_sel) begin
			sub_in.done       = lin_out.done;
			sub_in.rdy        = lin_out.rdy;
			sub_in.rd_trigger = lin_out.rd_trigger;
			sub_in.success    = lin_out.success;
			sub_in.newline    = lin_out.newline;
		end else if (arc_sel) begin
			sub_in.done       = arc_out.done;
			sub_in.rdy        = arc_out.rdy;
			sub_in.rd_trigger = arc_out.rd_trigger;
			sub_in.success    = arc_out.success;
			sub_in.newline    = arc_out.newline;
		end else begin
			sub_in.done       = skip_out.done;
			sub_in.rdy        = skip_out.rdy;
			sub_in.rd_trigger = skip_out.rd_trigger;
			sub_in.success    = skip_out.success;
			sub_in.newline    = skip_out.newline;
		end
	end

endmodule : subparser_input_chooser

//--- tests/gcode_checker.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module gcode_checker import gcode_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              rd_trigger,
	input  logic                              is_empty,
	input  logic                              op_valid,
	input  logic                              op_error,
	input  op_cmd_e                           op_cmd,
	input  logic                              op_abs,
	input  logic signed [`GC_COORD_BITS-1:0]  op_x,
	input  logic signed [`GC_COORD_BITS-1:0]  op_y,
	input  logic signed [`GC_COORD_BITS-1:0]  op_i,
	input  logic signed [`GC_COORD_BITS-1:0]  op_j,
	output int                                n_results,
	output int                                n_fails
);

	// Expected operations, one entry per line, in line order
	bit                               exp_err_q[$];
	op_cmd_e                          exp_cmd_q[$];
	bit                               exp_abs_q[$];
	bit                               exp_coord_q[$];   // Coordinates meaningful
	logic signed [`GC_COORD_BITS-1:0] exp_x_q[$];
	logic signed [`GC_COORD_BITS-1:0] exp_y_q[$];
	logic signed [`GC_COORD_BITS-1:0] exp_i_q[$];
	logic signed [`GC_COORD_BITS-1:0] exp_j_q[$];

	int result_cnt = 0;
	int fail_cnt   = 0;

	assign n_results = result_cnt;
	assign n_fails   = fail_cnt;

	// Called by the testbench top for every generated line
	task automatic expect_op(input bit is_err, input op_cmd_e cmd, input bit abs_mode,
		input bit use_coords, input logic signed [`GC_COORD_BITS-1:0] x,
		input logic signed [`GC_COORD_BITS-1:0] y, input logic signed [`GC_COORD_BITS-1:0] i,
		input logic signed [`GC_COORD_BITS-1:0] j);
		exp_err_q.push_back(is_err);
		exp_cmd_q.push_back(cmd);
		exp_abs_q.push_back(abs_mode);
		exp_coord_q.push_back(use_coords);
		exp_x_q.push_back(x);
		exp_y_q.push_back(y);
		exp_i_q.push_back(i);
		exp_j_q.push_back(j);
	endtask

	task automatic compare_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			fail_cnt++;
		end
	endtask

	task automatic check_result(input int idx);
		compare_value("op_error", exp_err_q[idx], op_error);
		if (!exp_err_q[idx] && op_valid) begin
			compare_value("op_cmd", int'(exp_cmd_q[idx]), int'(op_cmd));
			compare_value("op_abs", exp_abs_q[idx], op_abs);
			if (exp_coord_q[idx]) begin   // Mode lines carry no coordinates
				compare_value("op_x", exp_x_q[idx], op_x);
				compare_value("op_y", exp_y_q[idx], op_y);
				compare_value("op_i", exp_i_q[idx], op_i);
				compare_value("op_j", exp_j_q[idx], op_j);
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs sampled mid-cycle, away from the rising edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		if (!rst_n) begin
			compare_value("op_valid", 0, op_valid);
			compare_value("op_error", 0, op_error);
			compare_value("rd_trigger", 0, rd_trigger);
			compare_value("op_abs", 1, op_abs);
		end else if (op_valid && op_error) begin
			$display("op_valid and op_error were both high at %0t", $time);
			fail_cnt++;
			result_cnt++;
		end else if (op_valid || op_error) begin
			if (result_cnt >= exp_err_q.size()) begin
				$display("A result arrived at %0t with no line outstanding", $time);
				fail_cnt++;
			end else begin
				check_result(result_cnt);
			end
			result_cnt++;
		end
	end

	// No request may reach an empty source
	always @(posedge clk) begin
		if (rst_n && is_empty)
			compare_value("rd_trigger", 0, rd_trigger);
	end

endmodule : gcode_checker

//--- tests/gcode_parser_tb.sv
`timescale 1ns/100ps

`include "gcode_defines.svh"

module gcode_parser_tb import gcode_pkg::*; ();

	localparam logic [31:0] SEED = 32'ha251;
	localparam int N_LINEAR     = 40;
	localparam int N_ARC        = 40;
	localparam int N_MODE       = 30;
	localparam int N_ERROR      = 40;   // Error and valid lines alternate
	localparam int N_MIXED      = 50;
	localparam int TOTAL_LINES  = N_LINEAR + N_ARC + N_MODE + N_ERROR + N_MIXED;
	localparam int MAX_LINE_LEN = 32;     // "G02 X-9999 Y-9999 I-9999 J-9999\n"
	localparam int WATCHDOG_NS  = TOTAL_LINES * MAX_LINE_LEN * 4 * 8;

	logic clk;
	logic rst_n;
	logic rd_trigger;
	logic rd_done;
	logic is_empty;
	logic op_valid;
	logic op_error;
	logic op_abs;
	logic [`GC_CHAR_BITS-1:0] rd_char;
	op_cmd_e op_cmd;
	logic signed [`GC_COORD_BITS-1:0] op_x;
	logic signed [`GC_COORD_BITS-1:0] op_y;
	logic signed [`GC_COORD_BITS-1:0] op_i;
	logic signed [`GC_COORD_BITS-1:0] op_j;
	int n_results;
	int n_fails;

	logic [31:0]              gen_rng;
	logic [`GC_CHAR_BITS-1:0] char_q[$];   // Text of all lines sent so far
	int                       lines_sent;
	bit                       mode_abs;    // Reference copy of the mode register

	tb_clock_gen i_clock (.clk(clk), .rst_n(rst_n));

	gcode_parser i_dut (
		.clk(clk), .rst_n(rst_n), .rd_trigger(rd_trigger), .rd_done(rd_done),
		.rd_char(rd_char), .is_empty(is_empty), .op_valid(op_valid), .op_error(op_error),
		.op_cmd(op_cmd), .op_abs(op_abs), .op_x(op_x), .op_y(op_y), .op_i(op_i), .op_j(op_j)
	);

	gcode_checker i_checker (
		.clk(clk), .rst_n(rst_n), .rd_trigger(rd_trigger), .is_empty(is_empty),
		.op_valid(op_valid), .op_error(op_error), .op_cmd(op_cmd), .op_abs(op_abs),
		.op_x(op_x), .op_y(op_y), .op_i(op_i), .op_j(op_j), .n_results(n_results),
		.n_fails(n_fails)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int rand_below(input int n);
		gen_rng = xorshift32(gen_rng);
		return int'(gen_rng % n);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Line generator and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic send_line(input string line);
		int k;
		for (k = 0; k < line.len(); k++)
			char_q.push_back(line[k]);
		lines_sent++;
	endtask

	task automatic random_number(output string text, output logic signed [`GC_COORD_BITS-1:0] value);
		int n_digits;
		int limit;
		int mag;
		int k;
		bit neg;
		n_digits = 1 + rand_below(`GC_MAX_DIGITS);
		limit    = 1;
		for (k = 0; k < n_digits; k++)
			limit = limit * 10;
		mag = rand_below(limit);
		neg = (rand_below(4) == 0);
		if (neg)
			text = $sformatf("-%0d", mag);
		else
			text = $sformatf("%0d", mag);
		value = `GC_COORD_BITS'(neg ? -mag : mag);
	endtask

	// Axes in random order, each one present or missing
	task automatic coord_line(input bit arc);
		string   letters;
		string   line;
		string   text;
		int      order[4];
		int      n_axes;
		int      coin;
		int      k;
		int      t;
		int      tmp;
		bit      first;
		op_cmd_e cmd;
		logic signed [`GC_COORD_BITS-1:0] val[4];
		logic signed [`GC_COORD_BITS-1:0] v;
		letters = "XYIJ";
		n_axes  = arc ? 4 : 2;
		coin    = rand_below(2);
		if (arc)
			cmd = (coin == 1) ? OP_CMD_G03 : OP_CMD_G02;
		else
			cmd = (coin == 1) ? OP_CMD_G01 : OP_CMD_G00;
		for (k = 0; k < 4; k++) begin
			order[k] = k;
			val[k]   = '0;   // Missing axis reads 0
		end
		for (k = n_axes - 1; k > 0; k--) begin
			t        = rand_below(k + 1);
			tmp      = order[k];
			order[k] = order[t];
			order[t] = tmp;
		end
		line  = $sformatf("G%02d ", (arc ? 2 : 0) + coin);
		first = 1'b1;
		for (k = 0; k < n_axes; k++) begin
			if (rand_below(10) < 8) begin
				random_number(text, v);
				val[order[k]] = v;
				if (!first)
					line = {line, " "};
				line  = {line, letters.substr(order[k], order[k]), text};
				first = 1'b0;
			end
		end
		send_line({line, "\n"});
		i_checker.expect_op(1'b0, cmd, mode_abs, 1'b1, val[0], val[1], val[2], val[3]);
	endtask

	task automatic mode_line();
		bit rel;
		rel      = (rand_below(2) == 1);
		mode_abs = !rel;
		if (rel) begin
			send_line("G91 \n");
			i_checker.expect_op(1'b0, OP_CMD_G91, mode_abs, 1'b0, '0, '0, '0, '0);
		end else begin
			send_line("G90 \n");
			i_checker.expect_op(1'b0, OP_CMD_G90, mode_abs, 1'b0, '0, '0, '0, '0);
		end
	endtask

	task automatic error_line();
		string bad;
		string pair;
		string line;
		int    pick;
		int    g;
		int    a;
		int    b;
		int    t;
		bad  = "XMTS";
		pick = rand_below(5);
		g    = rand_below(4);
		a    = rand_below(100);
		b    = rand_below(100);
		t    = rand_below(2);
		case (pick)
			0: line = $sformatf("G%02d X%0d\n", 4 + rand_below(86), a);   // Unknown G code
			1: line = $sformatf("%s%02d X%0d\n", bad.substr(g, g), g, a);
			2: begin                                                        // I or J in G00/G01
				pair = "IJ";
				line = $sformatf("G%02d X%0d %s%0d\n", g % 2, a, pair.substr(t, t), b);
			end
			3: line = $sformatf("G%02d X%0d\n", g, 10000 + rand_below(90000));
			default: begin                                                  // Repeated axis
				pair = "XY";
				line = $sformatf("G%02d X%0d Y%0d %s%0d\n", g, a, b, pair.substr(t, t), a);
			end
		endcase
		send_line(line);
		i_checker.expect_op(1'b1, OP_CMD_NONE, mode_abs, 1'b0, '0, '0, '0, '0);
	endtask

	task automatic pick_line(input int kind, input int idx);
		int pick;
		case (kind)
			0: coord_line(1'b0);
			1: coord_line(1'b1);
			2: begin
				pick = rand_below(3);
				if (pick == 0)
					mode_line();
				else
					coord_line(pick == 2);
			end
			3: begin
				if (idx % 2 == 0)
					error_line();
				else
					coord_line(rand_below(2) == 1);   // Must parse after the error
			end
			default: begin
				pick = rand_below(10);
				if (pick < 4)
					coord_line(1'b0);
				else if (pick < 7)
					coord_line(1'b1);
				else if (pick == 7)
					mode_line();
				else
					error_line();
			end
		endcase
	endtask

	task automatic run_batch(input int test_no, input string title, input int n_lines,
		input int kind);
		int fails_before;
		int k;
		fails_before = n_fails;
		for (k = 0; k < n_lines; k++)
			pick_line(kind, k);
		while (n_results < lines_sent)
			@(negedge clk);
		$display("test %0d %s: %0d lines, %0d failures", test_no, title, n_lines,
			n_fails - fails_before);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reader model and back-pressure
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : reader_model
		logic [31:0] rd_rng;
		int          delay;
		int          rd_idx;
		rd_done = 1'b0;
		rd_char = '0;
		rd_idx  = 0;
		rd_rng  = xorshift32(SEED ^ 32'h0000_1f1f);
		forever begin
			@(posedge clk);
			if (rd_trigger) begin
				rd_rng = xorshift32(rd_rng);
				delay  = 1 + int'(rd_rng % 3);
				repeat (delay) @(negedge clk);
				while (rd_idx >= char_q.size())
					@(negedge clk);
				rd_char = char_q[rd_idx];
				rd_done = 1'b1;
				rd_idx++;
				@(negedge clk);
				rd_done = 1'b0;
			end
		end
	end

	initial begin : empty_stalls
		logic [31:0] stall_rng;
		int          gap;
		int          len;
		is_empty  = 1'b0;
		stall_rng = xorshift32(SEED ^ 32'h0000_3c3c);
		forever begin
			stall_rng = xorshift32(stall_rng);
			gap       = int'(stall_rng % 20);
			stall_rng = xorshift32(stall_rng);
			len       = 1 + int'(stall_rng % 4);
			repeat (gap + 1) @(negedge clk);
			is_empty = 1'b1;
			repeat (len) @(negedge clk);
			is_empty = 1'b0;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with %0d of %0d results seen",
			WATCHDOG_NS, n_results, lines_sent);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : stimulus
		gen_rng    = SEED;
		mode_abs   = 1'b1;   // Absolute mode after reset
		lines_sent = 0;
		@(posedge rst_n);
		@(posedge clk);      // Reset-time samples all taken
		$display("test 1 reset values: %0d failures", n_fails);
		run_batch(2, "linear moves", N_LINEAR, 0);
		run_batch(3, "arc moves", N_ARC, 1);
		run_batch(4, "absolute and relative mode", N_MODE, 2);
		run_batch(5, "error lines and recovery", N_ERROR, 3);
		run_batch(6, "mixed lines under reader stalls", N_MIXED, 4);
		repeat (20) @(negedge clk);   // Catch any stray result
		$display("summary: %0d of %0d lines checked, %0d failures", n_results, TOTAL_LINES,
			n_fails);
		if (n_fails == 0 && n_results == TOTAL_LINES)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : gcode_parser_tb

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	// Reset held over three rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule : tb_clock_gen
